// File: source/mipsPkg.sv
package mipsPkg;

	localparam int DATA_W     = 32;
	localparam int REG_ADDR_W = 5;

	typedef logic [DATA_W-1:0]     dataT;
	typedef logic [REG_ADDR_W-1:0] regAddrT;

	// Primary opcode, bits 31:26
	typedef enum logic [5:0] {
		OP_RTYPE = 6'd0,
		OP_BEQ   = 6'd4,
		OP_BNE   = 6'd5,
		OP_ADDI  = 6'd8,
		OP_LW    = 6'd35,
		OP_SW    = 6'd43,
		OP_HALT  = 6'd63
	} opcodeT;

	// R-type function field, bits 5:0
	typedef enum logic [5:0] {
		FN_ADD = 6'd32,
		FN_SUB = 6'd34,
		FN_AND = 6'd36,
		FN_OR  = 6'd37,
		FN_SLT = 6'd42
	} functT;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} aluOpT;

	// Halt is the all-ones opcode
	localparam opcodeT HALT_OPCODE = OP_HALT;

endpackage

// File: source/fetchStage.sv
module fetchStage
	import mipsPkg::*;
#(
	parameter int IMEM_DEPTH = 256
) (
	input  logic clk,
	input  logic i_rst,
	input  logic i_instMemLoadEnable,
	input  dataT i_instMemWriteAddr,
	input  dataT i_instMemWriteData,
	input  logic i_stall,
	input  logic i_branchTaken,
	input  dataT i_branchTarget,
	input  logic i_haltSeen,
	output dataT o_instr,
	output dataT o_pcNext,
	output dataT o_pc
);

	localparam int IDX_W = $clog2(IMEM_DEPTH);

	dataT imem [IMEM_DEPTH];
	dataT pc;
	dataT pcPlusOne;
	dataT fetched;
	logic stopped; // Set by halt, cleared only by reset
	logic freeze;

	assign pcPlusOne = pc + 1;
	assign fetched   = imem[pc[IDX_W-1:0]];
	assign freeze    = stopped | i_haltSeen;
	assign o_pc      = pc;

	// Program load happens only under reset
	always_ff @(posedge clk) begin
		if (i_rst && i_instMemLoadEnable) begin
			imem[i_instMemWriteAddr[IDX_W-1:0]] <= i_instMemWriteData;
		end
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			pc      <= '0;
			stopped <= 1'b0;
		end else begin
			if (i_haltSeen) begin
				stopped <= 1'b1;
			end
			if (freeze) begin
				pc <= pc;
			end else if (i_branchTaken) begin
				pc <= i_branchTarget;
			end else if (!i_stall) begin
				pc <= pcPlusOne;
			end
		end
	end

	// IF/ID, all-zero word decodes as a bubble
	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_instr <= '0;
		end else if (i_branchTaken || freeze) begin
			o_instr <= '0; // Flush
		end else if (!i_stall) begin
			o_instr  <= fetched;
			o_pcNext <= pcPlusOne;
		end
	end

	pcFrozenAfterStop: assert property (@(posedge clk) disable iff (i_rst)
		stopped |=> $stable(pc));

endmodule

// File: source/decodeStage.sv
module decodeStage
	import mipsPkg::*;
(
	input  logic    clk,
	input  logic    i_rst,
	input  dataT    i_instr,
	input  dataT    i_pcNext,
	input  regAddrT i_exMemDest,
	input  logic    i_exMemRegWrite,
	input  logic    i_wbWrite,
	input  regAddrT i_wbReg,
	input  dataT    i_wbData,
	input  regAddrT i_debugRegAddr,
	output logic    o_stall,
	output logic    o_branchTaken,
	output dataT    o_branchTarget,
	output logic    o_haltSeen,
	output dataT    o_debugRegData,
	output dataT    o_rsVal,
	output dataT    o_rtVal,
	output regAddrT o_rs,
	output regAddrT o_rt,
	output dataT    o_imm,
	output regAddrT o_dest,
	output aluOpT   o_aluOp,
	output logic    o_aluSrcImm,
	output logic    o_memRead,
	output logic    o_memWrite,
	output logic    o_regWrite,
	output logic    o_halt
);

	dataT    regs [32];
	opcodeT  op;
	functT   funct;
	regAddrT rs, rt, rd, dest;
	dataT    imm, rsVal, rtVal;
	aluOpT   aluOp;
	logic    aluSrcImm, memRead, memWrite, regWrite, isHalt;
	logic    isBeq, isBne, usesRs, usesRt;
	logic    loadUse, branchHaz, condMet;

	function automatic logic hit(regAddrT src, regAddrT dst);
		return src != '0 && src == dst;
	endfunction

	// Register 0 reads zero, a same-cycle write passes through
	function automatic dataT regRead(regAddrT a);
		if (a == '0) return '0;
		if (i_wbWrite && i_wbReg == a) return i_wbData;
		return regs[a];
	endfunction

	assign op    = opcodeT'(i_instr[31:26]);
	assign funct = functT'(i_instr[5:0]);
	assign rs    = i_instr[25:21];
	assign rt    = i_instr[20:16];
	assign rd    = i_instr[15:11];
	assign imm   = {{16{i_instr[15]}}, i_instr[15:0]};

	always_comb begin
		aluOp = ALU_ADD;
		aluSrcImm = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		regWrite = 1'b0;
		isHalt = 1'b0;
		isBeq = 1'b0;
		isBne = 1'b0;
		usesRs = 1'b0;
		usesRt = 1'b0;
		dest = rt;
		case (op)
			OP_RTYPE: begin
				dest = rd;
				usesRs = 1'b1;
				usesRt = 1'b1;
				regWrite = 1'b1;
				case (funct)
					FN_ADD: aluOp = ALU_ADD;
					FN_SUB: aluOp = ALU_SUB;
					FN_AND: aluOp = ALU_AND;
					FN_OR: aluOp = ALU_OR;
					FN_SLT: aluOp = ALU_SLT;
					default: regWrite = 1'b0; // Unknown funct is a no-op
				endcase
			end
			OP_ADDI: begin
				usesRs = 1'b1;
				aluSrcImm = 1'b1;
				regWrite = 1'b1;
			end
			OP_LW: begin
				usesRs = 1'b1;
				aluSrcImm = 1'b1;
				memRead = 1'b1;
				regWrite = 1'b1;
			end
			OP_SW: begin
				usesRs = 1'b1;
				usesRt = 1'b1;
				aluSrcImm = 1'b1;
				memWrite = 1'b1;
			end
			OP_BEQ: begin
				isBeq = 1'b1;
				usesRs = 1'b1;
				usesRt = 1'b1;
			end
			OP_BNE: begin
				isBne = 1'b1;
				usesRs = 1'b1;
				usesRt = 1'b1;
			end
			OP_HALT: isHalt = 1'b1;
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (i_wbWrite && i_wbReg != '0) begin
			regs[i_wbReg] <= i_wbData;
		end
	end

	always_comb begin
		rsVal = regRead(rs);
		rtVal = regRead(rt);
		o_debugRegData = regRead(i_debugRegAddr);
	end

	// Load in EX feeding this instruction
	assign loadUse = o_memRead &&
		((usesRs && hit(rs, o_dest)) || (usesRt && hit(rt, o_dest)));
	// No compare forwarding, so wait for producers to reach writeback
	assign branchHaz = (isBeq || isBne) && (
		(o_regWrite && (hit(rs, o_dest) || hit(rt, o_dest))) ||
		(i_exMemRegWrite && (hit(rs, i_exMemDest) || hit(rt, i_exMemDest))));

	assign condMet        = isBeq ? (rsVal == rtVal) : (rsVal != rtVal);
	assign o_stall        = loadUse | branchHaz;
	assign o_branchTaken  = (isBeq | isBne) & condMet & ~branchHaz;
	assign o_branchTarget = i_pcNext + imm;
	assign o_haltSeen     = isHalt;

	// ID/EX
	always_ff @(posedge clk) begin
		if (i_rst || o_stall) begin
			o_memRead  <= 1'b0;
			o_memWrite <= 1'b0;
			o_regWrite <= 1'b0;
			o_halt     <= 1'b0;
		end else begin
			o_memRead  <= memRead;
			o_memWrite <= memWrite;
			o_regWrite <= regWrite;
			o_halt     <= isHalt;
		end
		o_rsVal     <= rsVal;
		o_rtVal     <= rtVal;
		o_rs        <= rs;
		o_rt        <= rt;
		o_imm       <= imm;
		o_dest      <= dest;
		o_aluOp     <= aluOp;
		o_aluSrcImm <= aluSrcImm;
	end

	// A load in EX writing a branch source is also a branch hazard
	noBranchWhileStalled: assert property (@(posedge clk) disable iff (i_rst)
		!(o_branchTaken && o_stall));

endmodule

// File: source/executeStage.sv
module executeStage
	import mipsPkg::*;
(
	input  logic    clk,
	input  logic    i_rst,
	input  dataT    i_rsVal,
	input  dataT    i_rtVal,
	input  regAddrT i_rs,
	input  regAddrT i_rt,
	input  dataT    i_imm,
	input  regAddrT i_dest,
	input  aluOpT   i_aluOp,
	input  logic    i_aluSrcImm,
	input  logic    i_memRead,
	input  logic    i_memWrite,
	input  logic    i_regWrite,
	input  logic    i_halt,
	input  logic    i_wbWrite,
	input  regAddrT i_wbReg,
	input  dataT    i_wbData,
	output dataT    o_aluResult,
	output dataT    o_storeData,
	output regAddrT o_dest,
	output logic    o_memRead,
	output logic    o_memWrite,
	output logic    o_regWrite,
	output logic    o_halt
);

	dataT opA, opB, rtFwd, result;

	// Youngest producer wins, loads in EX/MEM are covered by the stall
	function automatic dataT forward(regAddrT r, dataT regVal);
		if (r != '0 && o_regWrite && !o_memRead && o_dest == r) return o_aluResult;
		if (r != '0 && i_wbWrite && i_wbReg == r) return i_wbData;
		return regVal;
	endfunction

	always_comb begin
		opA   = forward(i_rs, i_rsVal);
		rtFwd = forward(i_rt, i_rtVal);
		opB   = i_aluSrcImm ? i_imm : rtFwd;
	end

	always_comb begin
		case (i_aluOp)
			ALU_ADD: result = opA + opB;
			ALU_SUB: result = opA - opB;
			ALU_AND: result = opA & opB;
			ALU_OR: result = opA | opB;
			ALU_SLT: result = {31'b0, $signed(opA) < $signed(opB)};
			default: result = '0;
		endcase
	end

	// EX/MEM
	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_memRead  <= 1'b0;
			o_memWrite <= 1'b0;
			o_regWrite <= 1'b0;
			o_halt     <= 1'b0;
		end else begin
			o_memRead  <= i_memRead;
			o_memWrite <= i_memWrite;
			o_regWrite <= i_regWrite;
			o_halt     <= i_halt;
		end
		o_aluResult <= result;
		o_storeData <= rtFwd; // Store data needs forwarding too
		o_dest      <= i_dest;
	end

	validAluOp: assert property (@(posedge clk) disable iff (i_rst)
		i_regWrite |-> i_aluOp inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT});

endmodule

// File: source/memWriteback.sv
module memWriteback
	import mipsPkg::*;
#(
	parameter int DMEM_DEPTH = 256
) (
	input  logic    clk,
	input  logic    i_rst,
	input  dataT    i_aluResult,
	input  dataT    i_storeData,
	input  regAddrT i_dest,
	input  logic    i_memRead,
	input  logic    i_memWrite,
	input  logic    i_regWrite,
	input  logic    i_halt,
	output logic    o_wbWrite,
	output regAddrT o_wbReg,
	output dataT    o_wbData,
	output logic    o_debugHalt,
	output dataT    o_cycleCount
);

	localparam int IDX_W = $clog2(DMEM_DEPTH);

	dataT dmem [DMEM_DEPTH];
	dataT loadData;
	dataT wbAlu, wbLoad;
	logic wbIsLoad;
	logic wbHalt;

	assign loadData = dmem[i_aluResult[IDX_W-1:0]]; // Word addressed

	always_ff @(posedge clk) begin
		if (i_memWrite) begin
			dmem[i_aluResult[IDX_W-1:0]] <= i_storeData;
		end
	end

	// MEM/WB
	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_wbWrite <= 1'b0;
			wbHalt    <= 1'b0;
		end else begin
			o_wbWrite <= i_regWrite;
			wbHalt    <= i_halt;
		end
		o_wbReg  <= i_dest;
		wbAlu    <= i_aluResult;
		wbLoad   <= loadData;
		wbIsLoad <= i_memRead;
	end

	assign o_wbData = wbIsLoad ? wbLoad : wbAlu;

	// Sticky halt, counter stops with it
	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_debugHalt  <= 1'b0;
			o_cycleCount <= '0;
		end else begin
			if (wbHalt) begin
				o_debugHalt <= 1'b1;
			end
			if (!o_debugHalt) begin
				o_cycleCount <= o_cycleCount + 1;
			end
		end
	end

	noReadAndWrite: assert property (@(posedge clk) disable iff (i_rst)
		!(i_memRead && i_memWrite));

endmodule

// File: source/mipsCore.sv
module mipsCore
	import mipsPkg::*;
#(
	parameter int IMEM_DEPTH = 256,
	parameter int DMEM_DEPTH = 256
) (
	input  logic    clk,
	input  logic    i_rst,
	input  bit      i_instMemLoadEnable,
	input  dataT    i_instMemWriteAddr,
	input  dataT    i_instMemWriteData,
	input  regAddrT i_debugRegAddr,
	output dataT    o_debugRegData,
	output bit      o_debugHalt,
	output dataT    o_debugPc,
	output dataT    o_cycleCount
);

	// IF to ID and back
	dataT    ifInstr, ifPcNext, branchTarget;
	logic    stall, branchTaken, haltSeen;
	// ID/EX
	dataT    idRsVal, idRtVal, idImm;
	regAddrT idRs, idRt, idDest;
	aluOpT   idAluOp;
	logic    idAluSrcImm, idMemRead, idMemWrite, idRegWrite, idHalt;
	// EX/MEM
	dataT    exAluResult, exStoreData;
	regAddrT exDest;
	logic    exMemRead, exMemWrite, exRegWrite, exHalt;
	// Writeback port
	logic    wbWrite;
	regAddrT wbReg;
	dataT    wbData;

	fetchStage #(.IMEM_DEPTH(IMEM_DEPTH)) i_fetchStage (
		.clk                (clk                ),
		.i_rst              (i_rst              ),
		.i_instMemLoadEnable(i_instMemLoadEnable),
		.i_instMemWriteAddr (i_instMemWriteAddr ),
		.i_instMemWriteData (i_instMemWriteData ),
		.i_stall            (stall              ),
		.i_branchTaken      (branchTaken        ),
		.i_branchTarget     (branchTarget       ),
		.i_haltSeen         (haltSeen           ),
		.o_instr            (ifInstr            ),
		.o_pcNext           (ifPcNext           ),
		.o_pc               (o_debugPc          )
	);

	decodeStage i_decodeStage (
		.clk            (clk           ),
		.i_rst          (i_rst         ),
		.i_instr        (ifInstr       ),
		.i_pcNext       (ifPcNext      ),
		.i_exMemDest    (exDest        ),
		.i_exMemRegWrite(exRegWrite    ),
		.i_wbWrite      (wbWrite       ),
		.i_wbReg        (wbReg         ),
		.i_wbData       (wbData        ),
		.i_debugRegAddr (i_debugRegAddr),
		.o_stall        (stall         ),
		.o_branchTaken  (branchTaken   ),
		.o_branchTarget (branchTarget  ),
		.o_haltSeen     (haltSeen      ),
		.o_debugRegData (o_debugRegData),
		.o_rsVal        (idRsVal       ),
		.o_rtVal        (idRtVal       ),
		.o_rs           (idRs          ),
		.o_rt           (idRt          ),
		.o_imm          (idImm         ),
		.o_dest         (idDest        ),
		.o_aluOp        (idAluOp       ),
		.o_aluSrcImm    (idAluSrcImm   ),
		.o_memRead      (idMemRead     ),
		.o_memWrite     (idMemWrite    ),
		.o_regWrite     (idRegWrite    ),
		.o_halt         (idHalt        )
	);

	executeStage i_executeStage (
		.clk        (clk        ),
		.i_rst      (i_rst      ),
		.i_rsVal    (idRsVal    ),
		.i_rtVal    (idRtVal    ),
		.i_rs       (idRs       ),
		.i_rt       (idRt       ),
		.i_imm      (idImm      ),
		.i_dest     (idDest     ),
		.i_aluOp    (idAluOp    ),
		.i_aluSrcImm(idAluSrcImm),
		.i_memRead  (idMemRead  ),
		.i_memWrite (idMemWrite ),
		.i_regWrite (idRegWrite ),
		.i_halt     (idHalt     ),
		.i_wbWrite  (wbWrite    ),
		.i_wbReg    (wbReg      ),
		.i_wbData   (wbData     ),
		.o_aluResult(exAluResult),
		.o_storeData(exStoreData),
		.o_dest     (exDest     ),
		.o_memRead  (exMemRead  ),
		.o_memWrite (exMemWrite ),
		.o_regWrite (exRegWrite ),
		.o_halt     (exHalt     )
	);

	memWriteback #(.DMEM_DEPTH(DMEM_DEPTH)) i_memWriteback (
		.clk         (clk         ),
		.i_rst       (i_rst       ),
		.i_aluResult (exAluResult ),
		.i_storeData (exStoreData ),
		.i_dest      (exDest      ),
		.i_memRead   (exMemRead   ),
		.i_memWrite  (exMemWrite  ),
		.i_regWrite  (exRegWrite  ),
		.i_halt      (exHalt      ),
		.o_wbWrite   (wbWrite     ),
		.o_wbReg     (wbReg       ),
		.o_wbData    (wbData      ),
		.o_debugHalt (o_debugHalt ),
		.o_cycleCount(o_cycleCount)
	);

endmodule

// File: verif/tbIsaModel.svh
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

// R-type word, shamt always zero
function automatic dataT encR(functT fn, int rd, int rs, int rt);
	return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
endfunction

// I-type word, also used for halt with all fields zero
function automatic dataT encI(opcodeT op, int rt, int rs, int imm);
	return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

function automatic logic [31:0] xorshift(logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	return y ^ (y << 5);
endfunction

function automatic void setReg(logic [4:0] r, dataT v);
	if (r != 5'd0) begin
		modelRegs[r] = v; // r0 stays zero
	end
endfunction

// One instruction per step, no pipeline, stops at halt
function automatic void runModel();
	int   pc;
	int   off;
	dataT ins, a, b, imm, addr;
	pc = 0;
	for (int n = 0; n < 1000; n++) begin
		ins  = prog[pc];
		a    = modelRegs[ins[25:21]];
		b    = modelRegs[ins[20:16]];
		imm  = {{16{ins[15]}}, ins[15:0]};
		off  = int'($signed(ins[15:0]));
		addr = a + imm;
		pc++;
		case (ins[31:26])
			OP_RTYPE: begin
				case (ins[5:0])
					FN_ADD: setReg(ins[15:11], a + b);
					FN_SUB: setReg(ins[15:11], a - b);
					FN_AND: setReg(ins[15:11], a & b);
					FN_OR: setReg(ins[15:11], a | b);
					FN_SLT: setReg(ins[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
					default: ;
				endcase
			end
			OP_ADDI: setReg(ins[20:16], a + imm);
			OP_LW: setReg(ins[20:16], modelMem[addr[7:0]]);
			OP_SW: modelMem[addr[7:0]] = b;
			OP_BEQ: if (a == b) pc += off; // Target relative to the next word
			OP_BNE: if (a != b) pc += off;
			OP_HALT: return;
			default: ;
		endcase
	end
endfunction

`endif

// File: verif/mipsCoreTb.sv
module mipsCoreTb
	import mipsPkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALT_TIMEOUT = 1000;

	logic    clk;
	logic    i_rst;
	bit      i_instMemLoadEnable;
	dataT    i_instMemWriteAddr;
	dataT    i_instMemWriteData;
	regAddrT i_debugRegAddr;
	dataT    o_debugRegData;
	bit      o_debugHalt;
	dataT    o_debugPc;
	dataT    o_cycleCount;

	dataT        prog [$];
	dataT        modelRegs [32];
	dataT        modelMem [256];
	logic [31:0] rngState;
	functT       fnTable [5];

	`include "tbIsaModel.svh"

	mipsCore i_mipsCore (
		.clk                (clk                ),
		.i_rst              (i_rst              ),
		.i_instMemLoadEnable(i_instMemLoadEnable),
		.i_instMemWriteAddr (i_instMemWriteAddr ),
		.i_instMemWriteData (i_instMemWriteData ),
		.i_debugRegAddr     (i_debugRegAddr     ),
		.o_debugRegData     (o_debugRegData     ),
		.o_debugHalt        (o_debugHalt        ),
		.o_debugPc          (o_debugPc          ),
		.o_cycleCount       (o_cycleCount       )
	);

	always #5 clk = ~clk;

	task automatic stopWithError(string line);
		$display("%s", line);
		$display("tests failed");
		$fatal(1);
	endtask

	function automatic string valueError(string what, dataT got, dataT want);
		return $sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, want);
	endfunction

	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic buildRandomProgram();
		int sel;
		prog.delete();
		for (int r = 1; r < 8; r++) begin
			rngState = xorshift(rngState);
			prog.push_back(encI(OP_ADDI, r, 0, int'(rngState[15:0])));
		end
		for (int n = 0; n < 12; n++) begin
			rngState = xorshift(rngState);
			sel = int'(rngState[31:29]);
			if (sel < 5) begin
				prog.push_back(encR(fnTable[sel], int'(rngState[2:0]),
					int'(rngState[5:3]), int'(rngState[8:6])));
			end else begin
				prog.push_back(encI(OP_ADDI, int'(rngState[2:0]),
					int'(rngState[5:3]), int'(rngState[24:9])));
			end
		end
		prog.push_back(encI(OP_HALT, 0, 0, 0));
	endtask

	// Load under reset, run to halt, then compare all registers
	task automatic runProgram();
		int   cycles;
		dataT pcHold;
		dataT countHold;
		i_rst = 1'b1;
		foreach (prog[i]) begin
			i_instMemLoadEnable = 1'b1;
			i_instMemWriteAddr  = i;
			i_instMemWriteData  = prog[i];
			nextCycle();
		end
		i_instMemLoadEnable = 1'b0;
		repeat (5) nextCycle();
		i_rst = 1'b0;
		runModel();
		assert (o_debugHalt == 1'b0)
			else stopWithError(valueError("halt flag", 32'(o_debugHalt), 0));
		assert (o_cycleCount == 0) else stopWithError(valueError("cycle count", o_cycleCount, 0));
		assert (o_debugPc == 0) else stopWithError(valueError("PC", o_debugPc, 0));
		cycles = 0;
		while (o_debugPc === '0) begin
			if (cycles == 4) stopWithError("The PC did not advance after reset");
			nextCycle();
			cycles++;
		end
		// Counter also steps on the edge that raises halt
		while (o_debugHalt !== 1'b1) begin
			if (cycles == HALT_TIMEOUT) stopWithError("Timeout: the core never raised its halt flag");
			nextCycle();
			cycles++;
		end
		assert (o_cycleCount === dataT'(cycles))
			else stopWithError(valueError("cycle count at halt", o_cycleCount, dataT'(cycles)));
		pcHold    = o_debugPc;
		countHold = o_cycleCount;
		repeat (20) begin
			nextCycle();
			assert (o_debugPc === pcHold)
				else stopWithError(valueError("PC after halt", o_debugPc, pcHold));
			assert (o_cycleCount === countHold)
				else stopWithError(valueError("cycle count after halt", o_cycleCount, countHold));
		end
		foreach (modelRegs[r]) begin
			i_debugRegAddr = 5'(r);
			#4; // Debug read is combinational
			assert (o_debugRegData === modelRegs[r])
				else stopWithError(valueError($sformatf("register %0d", r),
					o_debugRegData, modelRegs[r]));
			nextCycle();
		end
	endtask

	initial begin
		clk                 = 1'b0;
		i_rst               = 1'b1;
		i_instMemLoadEnable = 1'b0;
		i_instMemWriteAddr  = '0;
		i_instMemWriteData  = '0;
		i_debugRegAddr      = '0;
		rngState            = 32'd33;
		fnTable             = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT};
		foreach (modelRegs[i]) begin
			modelRegs[i] = '0;
		end

		// Known value in every register
		prog.delete();
		for (int r = 1; r < 32; r++) begin
			prog.push_back(encI(OP_ADDI, r, 0, r * 3 + 1));
		end
		prog.push_back(encI(OP_HALT, 0, 0, 0));
		runProgram();

		// Dependent ALU chain
		prog.delete();
		prog.push_back(encI(OP_ADDI, 1, 0, 7));
		prog.push_back(encI(OP_ADDI, 2, 1, -3));
		prog.push_back(encR(FN_ADD, 3, 1, 2));
		prog.push_back(encR(FN_SUB, 4, 3, 1));
		prog.push_back(encR(FN_AND, 5, 4, 3));
		prog.push_back(encR(FN_OR, 6, 5, 3));
		prog.push_back(encR(FN_SLT, 7, 2, 6));
		prog.push_back(encR(FN_SLT, 8, 6, 2));
		prog.push_back(encI(OP_ADDI, 9, 0, -5));
		prog.push_back(encR(FN_SLT, 10, 9, 1)); // Signed compare
		prog.push_back(encI(OP_HALT, 0, 0, 0));
		runProgram();

		// Loads, stores and load-use stalls
		prog.delete();
		prog.push_back(encI(OP_ADDI, 1, 0, 40));
		prog.push_back(encI(OP_ADDI, 2, 0, 123));
		prog.push_back(encI(OP_SW, 2, 1, 0));
		prog.push_back(encI(OP_LW, 3, 1, 0));
		prog.push_back(encR(FN_ADD, 4, 3, 1));
		prog.push_back(encI(OP_LW, 5, 1, 0));
		prog.push_back(encI(OP_BEQ, 2, 5, 1)); // Branch on a fresh load
		prog.push_back(encI(OP_ADDI, 6, 0, 99));
		prog.push_back(encI(OP_SW, 4, 1, 1));
		prog.push_back(encI(OP_LW, 7, 1, 1));
		prog.push_back(encI(OP_HALT, 0, 0, 0));
		runProgram();

		// Branches taken and not taken, addi after halt
		prog.delete();
		prog.push_back(encI(OP_ADDI, 1, 0, 5));
		prog.push_back(encI(OP_ADDI, 2, 0, 5));
		prog.push_back(encI(OP_BEQ, 2, 1, 1));
		prog.push_back(encI(OP_ADDI, 3, 0, 99));
		prog.push_back(encI(OP_ADDI, 4, 0, 7));
		prog.push_back(encI(OP_BNE, 4, 1, 1));
		prog.push_back(encI(OP_ADDI, 5, 0, 99));
		prog.push_back(encI(OP_BEQ, 4, 1, 1));
		prog.push_back(encI(OP_ADDI, 6, 0, 21));
		prog.push_back(encR(FN_SUB, 7, 1, 2));
		prog.push_back(encI(OP_BNE, 0, 7, 1));
		prog.push_back(encI(OP_ADDI, 8, 0, 12));
		prog.push_back(encI(OP_HALT, 0, 0, 0));
		prog.push_back(encI(OP_ADDI, 12, 0, 77));
		runProgram();

		repeat (20) begin
			buildRandomProgram();
			runProgram();
		end

		$display("all tests passed");
		$finish;
	end

endmodule

// File: list.f
+incdir+verif
source/mipsPkg.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memWriteback.sv
source/mipsCore.sv
verif/mipsCoreTb.sv

// File: run.sh
#!/bin/bash
# Build with Verilator, run, and look for the pass message in the output

cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -f list.f --top-module mipsCoreTb -o simv \
	&& ./obj_dir/simv | tee /dev/stderr | grep -qF "all tests passed" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
